//--- build.f
rtl/lsu_pkg.sv
rtl/load_req_if.sv
rtl/load_entry.sv
rtl/load_queue.sv
rtl/load_mem_port.sv
rtl/load_unit_top.sv
verification/apb_mem_model.sv
verification/load_unit_tb.sv

//--- Bender.yml
package:
  name: load_unit

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/load_req_if.sv
      - rtl/load_entry.sv
      - rtl/load_queue.sv
      - rtl/load_mem_port.sv
      - rtl/load_unit_top.sv
  - target: simulation
    files:
      - verification/apb_mem_model.sv
      - verification/load_unit_tb.sv

//--- verification/load_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit_tb import lsu_pkg::*; ();

	localparam int timeout_cycles = 200;
	localparam int num_rows       = 13;
	localparam int rob_count      = 2 ** rob_w;

	typedef struct packed {
		logic [rob_w-1:0] rob;
		logic [tag_w-1:0] dest_tag;
		logic             base_ready;
		logic [xlen-1:0]  base;        // Producer tag in low bits when not ready
		logic [xlen-1:0]  imm;
		logic             has_cdb;
		logic [xlen-1:0]  cdb_data;
	} load_row_t;

	// rob, dest tag, base ready, base or tag, imm, CDB follows, CDB data
	load_row_t rows [num_rows] = '{
		'{5'd1,  6'h10, 1'b1, 32'h0000_1000, 32'h0000_0010, 1'b0, 32'h0000_0000},
		'{5'd2,  6'h11, 1'b1, 32'h8000_0040, 32'hffff_fffc, 1'b0, 32'h0000_0000},
		'{5'd3,  6'h12, 1'b0, 32'h0000_0021, 32'h0000_0008, 1'b1, 32'h2000_0100},
		'{5'd4,  6'h13, 1'b1, 32'h0000_2000, 32'h0000_0004, 1'b0, 32'h0000_0000},
		'{5'd5,  6'h14, 1'b1, 32'h0000_3000, 32'h0000_0008, 1'b0, 32'h0000_0000},
		'{5'd6,  6'h15, 1'b1, 32'h1234_5670, 32'h0000_0000, 1'b0, 32'h0000_0000},
		'{5'd7,  6'h16, 1'b1, 32'h0000_4000, 32'h0000_0100, 1'b0, 32'h0000_0000},
		'{5'd8,  6'h17, 1'b1, 32'h0000_5000, 32'h0000_0000, 1'b0, 32'h0000_0000},
		'{5'd9,  6'h18, 1'b1, 32'h0000_6000, 32'h0000_000c, 1'b0, 32'h0000_0000},
		'{5'd10, 6'h19, 1'b1, 32'h0000_7000, 32'h0000_0010, 1'b0, 32'h0000_0000},
		'{5'd11, 6'h1a, 1'b0, 32'h0000_002a, 32'h0000_0000, 1'b0, 32'h0000_0000},
		'{5'd12, 6'h1b, 1'b1, 32'h0000_8000, 32'h0000_0020, 1'b0, 32'h0000_0000},
		'{5'd13, 6'h1c, 1'b0, 32'h0000_002b, 32'h0000_0004, 1'b1, 32'h0000_9000}
	};

	logic             clock;
	logic             reset;
	logic             flush;
	logic             dispatch_valid;
	logic             dispatch_ready;
	logic [rob_w-1:0] dispatch_rob_idx;
	logic [tag_w-1:0] dispatch_dest_tag;
	logic             dispatch_base_ready;
	logic [xlen-1:0]  dispatch_base;
	logic [xlen-1:0]  dispatch_imm;
	logic             cdb_valid;
	logic [tag_w-1:0] cdb_tag;
	logic [xlen-1:0]  cdb_data;
	logic             wb_valid;
	logic             wb_ready;
	logic [rob_w-1:0] wb_rob_idx;
	logic [tag_w-1:0] wb_dest_tag;
	logic [xlen-1:0]  wb_data;
	logic [xlen-1:0]  paddr;
	logic             psel;
	logic             penable;
	logic             pwrite;
	logic [xlen-1:0]  prdata;
	logic             pready;
	logic             pslverr;

	// Scoreboard by ROB index
	bit               pending    [rob_count];
	bit               released   [rob_count];    // Base known, writeback allowed
	bit               addr_known [rob_count];
	logic [xlen-1:0]  exp_addr   [rob_count];
	logic [xlen-1:0]  exp_data   [rob_count];
	logic [tag_w-1:0] exp_tag    [rob_count];
	int               wb_count;
	int               expected_wb;

	bit               hold_seen;    // Writeback stalled at the last edge
	logic [rob_w-1:0] held_rob;
	logic [tag_w-1:0] held_tag;
	logic [xlen-1:0]  held_data;

	bit               prev_psel;    // APB phase seen at the last edge
	bit               prev_penable;
	bit               prev_pready;

	load_unit_top uut (.*);

	apb_mem_model u_mem (
		.clock   (clock),
		.reset   (reset),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
		return ~{addr[15:0], addr[31:16]};
	endfunction

	function automatic bit addr_expected(input logic [xlen-1:0] addr);
		bit found;
		found = 1'b0;
		for (int i = 0; i < rob_count; i++) begin
			if (addr_known[i] && exp_addr[i] == addr) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [xlen-1:0] got,
			input logic [xlen-1:0] expected);
		if (got !== expected) begin
			stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
		end
	endtask

	task automatic dispatch_row(input int r);
		int waited;
		logic [rob_w-1:0] rob;
		waited = 0;
		while (!dispatch_ready && waited < timeout_cycles) begin
			@(negedge clock);
			waited++;
		end
		if (!dispatch_ready) begin
			stop_with_failure("Timed out waiting for dispatch_ready to accept a load");
		end
		rob = rows[r].rob;
		pending[rob]    = 1'b1;
		released[rob]   = rows[r].base_ready;
		addr_known[rob] = rows[r].base_ready;
		exp_tag[rob]    = rows[r].dest_tag;
		exp_addr[rob]   = (rows[r].base_ready ? rows[r].base : rows[r].cdb_data) + rows[r].imm;
		exp_data[rob]   = mem_word(exp_addr[rob]);
		expected_wb++;
		dispatch_valid      = 1'b1;
		dispatch_rob_idx    = rob;
		dispatch_dest_tag   = rows[r].dest_tag;
		dispatch_base_ready = rows[r].base_ready;
		dispatch_base       = rows[r].base;
		dispatch_imm        = rows[r].imm;
		@(negedge clock);
		dispatch_valid = 1'b0;
	endtask

	task automatic run_rows(input int first, input int last);
		for (int r = first; r <= last; r++) begin
			dispatch_row(r);
		end
		// Producers of the waiting rows broadcast once the group is queued
		for (int r = first; r <= last; r++) begin
			if (rows[r].has_cdb) begin
				release_row(r);
			end
		end
	endtask

	task automatic broadcast_cdb(input logic [tag_w-1:0] tag, input logic [xlen-1:0] value);
		cdb_valid = 1'b1;
		cdb_tag   = tag;
		cdb_data  = value;
		@(negedge clock);
		cdb_valid = 1'b0;
	endtask

	// Producer of a waiting row broadcasts its value
	task automatic release_row(input int r);
		released[rows[r].rob]   = 1'b1;
		addr_known[rows[r].rob] = 1'b1;
		broadcast_cdb(rows[r].base[tag_w-1:0], rows[r].cdb_data);
	endtask

	task automatic wait_for_writebacks(input int target);
		int waited;
		waited = 0;
		while (wb_count < target && waited < timeout_cycles) begin
			@(negedge clock);
			waited++;
		end
		if (wb_count < target) begin
			stop_with_failure("Timed out waiting for loads to write back");
		end
	endtask

	task automatic wait_for_wb_valid();
		int waited;
		waited = 0;
		while (!wb_valid && waited < timeout_cycles) begin
			@(negedge clock);
			waited++;
		end
		if (!wb_valid) begin
			stop_with_failure("Timed out waiting for wb_valid");
		end
	endtask

	task automatic wait_for_psel();
		int waited;
		waited = 0;
		while (!psel && waited < timeout_cycles) begin
			@(negedge clock);
			waited++;
		end
		if (!psel) begin
			stop_with_failure("Timed out waiting for an APB transfer to start");
		end
	endtask

	task automatic expect_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			check_value("wb_valid", wb_valid, 1'b0);
			@(negedge clock);
		end
	endtask

	// Flush drops every load still in flight
	task automatic drop_outstanding();
		for (int i = 0; i < rob_count; i++) begin
			if (pending[i]) begin
				pending[i] = 1'b0;
				expected_wb--;
			end
		end
	endtask

	function automatic int count_pending();
		int n;
		n = 0;
		for (int i = 0; i < rob_count; i++) begin
			n += pending[i];
		end
		return n;
	endfunction

	// Writeback scoreboard and APB address monitor
	always @(posedge clock) begin
		if (!reset) begin
			if (hold_seen) begin
				check_value("wb_valid", wb_valid, 1'b1);
				check_value("wb_rob_idx", wb_rob_idx, held_rob);
				check_value("wb_dest_tag", wb_dest_tag, held_tag);
				check_value("wb_data", wb_data, held_data);
			end
			if (wb_valid && wb_ready) begin
				if (!pending[wb_rob_idx]) begin
					stop_with_failure("Writeback for a ROB index with no load outstanding");
				end
				if (!released[wb_rob_idx]) begin
					stop_with_failure("Writeback arrived before the base was broadcast");
				end
				check_value("wb_dest_tag", wb_dest_tag, exp_tag[wb_rob_idx]);
				check_value("wb_data", wb_data, exp_data[wb_rob_idx]);
				pending[wb_rob_idx] = 1'b0;
				wb_count++;
			end
			if (psel) begin
				check_value("pwrite", pwrite, 1'b0);
			end
			// Setup phase opens every transfer, access follows while selected
			check_value("penable", penable,
				psel && prev_psel && !(prev_penable && prev_pready));
			if (psel && !penable && !addr_expected(paddr)) begin
				stop_with_failure("APB read at an address that no load formed as base plus imm");
			end
			hold_seen    = wb_valid && !wb_ready && !flush;
			held_rob     = wb_rob_idx;
			held_tag     = wb_dest_tag;
			held_data    = wb_data;
			prev_psel    = psel;
			prev_penable = penable;
			prev_pready  = pready;
		end
	end

	initial begin
		void'($urandom(46));
		reset               = 1'b1;
		flush               = 1'b0;
		dispatch_valid      = 1'b0;
		dispatch_rob_idx    = '0;
		dispatch_dest_tag   = '0;
		dispatch_base_ready = 1'b0;
		dispatch_base       = '0;
		dispatch_imm        = '0;
		cdb_valid           = 1'b0;
		cdb_tag             = '0;
		cdb_data            = '0;
		wb_ready            = 1'b1;
		wb_count            = 0;
		expected_wb         = 0;
		hold_seen           = 1'b0;
		prev_psel           = 1'b0;
		prev_penable        = 1'b0;
		prev_pready         = 1'b0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		check_value("dispatch_ready", dispatch_ready, 1'b1);

		// Ready bases
		run_rows(0, 1);
		wait_for_writebacks(2);

		// Base from the CDB, a foreign tag first
		dispatch_row(2);
		expect_quiet(15);
		broadcast_cdb(6'h22, 32'hdead_beef);
		expect_quiet(10);
		release_row(2);
		wait_for_writebacks(3);

		// Full queue behind a stalled writeback
		wb_ready = 1'b0;
		run_rows(3, 6);
		check_value("dispatch_ready", dispatch_ready, 1'b0);
		wait_for_wb_valid();
		repeat (30) @(negedge clock);
		wb_ready = 1'b1;
		@(negedge clock);
		wb_ready = 1'b0;
		check_value("writeback count", wb_count, 4);
		check_value("dispatch_ready", dispatch_ready, 1'b1);
		wb_ready = 1'b1;
		wait_for_writebacks(7);

		// Flush while a transfer is on the bus
		wb_ready = 1'b0;
		run_rows(7, 10);
		wait_for_psel();
		flush = 1'b1;
		drop_outstanding();
		@(negedge clock);
		flush    = 1'b0;
		wb_ready = 1'b1;
		expect_quiet(20);
		check_value("writeback count", wb_count, 7);

		// Normal traffic after the flush
		run_rows(11, 12);
		wait_for_writebacks(9);
		@(negedge clock);

		if (wb_count == expected_wb && count_pending() == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			stop_with_failure("Writebacks do not match the loads that were dispatched");
		end
	end

endmodule

`default_nettype wire

//--- verification/apb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module apb_mem_model import lsu_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic [xlen-1:0] paddr,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	output logic [xlen-1:0] prdata,
	output logic            pready,
	output logic            pslverr
);

	logic [1:0] wait_left;    // Wait states still to insert in this access

	// Fresh wait count of 0 to 3 for every setup phase
	always @(posedge clock) begin
		if (reset) begin
			wait_left <= 2'd0;
		end else if (psel && !penable) begin
			wait_left <= 2'($urandom_range(3, 0));
		end else if (psel && penable && wait_left != 2'd0) begin
			wait_left <= wait_left - 2'd1;
		end
	end

	assign pready = psel && penable && (wait_left == 2'd0);

	// Halves of the address swapped, then inverted
	assign prdata = pwrite ? '0 : ~{paddr[15:0], paddr[31:16]};

	// Some addresses answer with an error, the data is still valid
	assign pslverr = pready && paddr[4];

endmodule

`default_nettype wire

//--- rtl/load_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit_top import lsu_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  logic             flush,

	// Dispatch
	input  logic             dispatch_valid,
	output logic             dispatch_ready,
	input  logic [rob_w-1:0] dispatch_rob_idx,
	input  logic [tag_w-1:0] dispatch_dest_tag,
	input  logic             dispatch_base_ready,
	input  logic [xlen-1:0]  dispatch_base,        // Producer tag in low bits when not ready
	input  logic [xlen-1:0]  dispatch_imm,

	// Common data bus
	input  logic             cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  logic [xlen-1:0]  cdb_data,

	// Writeback
	output logic             wb_valid,
	input  logic             wb_ready,
	output logic [rob_w-1:0] wb_rob_idx,
	output logic [tag_w-1:0] wb_dest_tag,
	output logic [xlen-1:0]  wb_data,

	// APB master
	output logic [xlen-1:0]  paddr,
	output logic             psel,
	output logic             penable,
	output logic             pwrite,
	input  logic [xlen-1:0]  prdata,
	input  logic             pready,
	input  logic             pslverr
);

	load_req_t  dispatch_req;
	load_req_if mem_if ();

	assign dispatch_req.rob_idx    = dispatch_rob_idx;
	assign dispatch_req.dest_tag   = dispatch_dest_tag;
	assign dispatch_req.base_ready = dispatch_base_ready;
	assign dispatch_req.base       = dispatch_base;
	assign dispatch_req.imm        = dispatch_imm;

	load_queue u_queue (
		.clock          (clock),
		.reset          (reset),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_req   (dispatch_req),
		.dispatch_ready (dispatch_ready),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data),
		.mem            (mem_if),
		.wb_valid       (wb_valid),
		.wb_ready       (wb_ready),
		.wb_rob_idx     (wb_rob_idx),
		.wb_dest_tag    (wb_dest_tag),
		.wb_data        (wb_data)
	);

	load_mem_port u_mem_port (
		.clock   (clock),
		.reset   (reset),
		.flush   (flush),
		.mem     (mem_if),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

endmodule

`default_nettype wire

//--- rtl/load_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module load_mem_port import lsu_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            flush,

	load_req_if.port        mem,

	// APB3 master
	output logic [xlen-1:0] paddr,
	output logic            psel,
	output logic            penable,
	output logic            pwrite,
	input  logic [xlen-1:0] prdata,
	input  logic            pready,
	input  logic            pslverr    // Error responses still return their data
);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_t;

	state_t              state;
	logic                discard;       // Owner was flushed mid transfer
	logic [lq_idx_w-1:0] index_q;
	logic                resp_valid_q;
	logic [lq_idx_w-1:0] resp_index_q;
	logic [xlen-1:0]     resp_data_q;
	logic                accept;
	logic                done;

	assign mem.req_ready = (state == st_idle) && !flush;
	assign accept        = mem.req_valid && mem.req_ready;
	assign done          = (state == st_access) && pready;

	assign psel    = (state != st_idle);
	assign penable = (state == st_access);
	assign pwrite  = 1'b0;    // Read only master

	assign mem.resp_valid = resp_valid_q;
	assign mem.resp_index = resp_index_q;
	assign mem.resp_data  = resp_data_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= st_idle;
			discard      <= 1'b0;
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= done && !discard && !flush;
			case (state)
				st_idle: begin
					discard <= 1'b0;
					if (accept) begin
						state <= st_setup;
					end
				end
				st_setup: begin
					state <= st_access;
					if (flush) begin
						discard <= 1'b1;
					end
				end
				st_access: begin
					if (flush) begin
						discard <= 1'b1;
					end
					if (pready) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			paddr   <= mem.req_addr;
			index_q <= mem.req_index;
		end
		if (done) begin
			resp_data_q  <= prdata;
			resp_index_q <= index_q;
		end
	end

	// Address must not move between setup and the end of access
	a_paddr_stable: assert property (
		@(posedge clock) disable iff (reset)
		psel && !done |=> $stable(paddr)
	);

endmodule

`default_nettype wire

//--- rtl/load_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue import lsu_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  logic             flush,

	// Dispatch
	input  logic             dispatch_valid,
	input  load_req_t        dispatch_req,
	output logic             dispatch_ready,

	// Common data bus
	input  logic             cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  logic [xlen-1:0]  cdb_data,

	// Memory port
	load_req_if.queue        mem,

	// Writeback
	output logic             wb_valid,
	input  logic             wb_ready,
	output logic [rob_w-1:0] wb_rob_idx,
	output logic [tag_w-1:0] wb_dest_tag,
	output logic [xlen-1:0]  wb_data
);

	logic [lq_depth-1:0] alloc;
	logic [lq_depth-1:0] issue_grant;
	logic [lq_depth-1:0] resp_hit;
	logic [lq_depth-1:0] release_grant;
	logic [lq_depth-1:0] busy;
	logic [lq_depth-1:0] addr_ready;
	logic [lq_depth-1:0] requested;
	logic [lq_depth-1:0] data_valid;
	logic [xlen-1:0]     addr     [lq_depth];
	logic [rob_w-1:0]    rob_idx  [lq_depth];
	logic [tag_w-1:0]    dest_tag [lq_depth];
	logic [xlen-1:0]     data     [lq_depth];

	logic                free_any;
	logic [lq_idx_w-1:0] free_idx;
	logic                issue_any;
	logic [lq_idx_w-1:0] issue_idx;
	logic                wb_any;
	logic [lq_idx_w-1:0] wb_pick;
	logic [lq_idx_w-1:0] wb_sel;
	logic                wb_hold;        // Writeback stalled last cycle
	logic [lq_idx_w-1:0] wb_hold_idx;

	// Lowest set bit wins, result is {found, index}
	function automatic logic [lq_idx_w:0] pick_lowest(input logic [lq_depth-1:0] req);
		logic [lq_idx_w:0] result;
		result = '0;
		for (int i = lq_depth - 1; i >= 0; i--) begin
			if (req[i]) begin
				result = {1'b1, lq_idx_w'(i)};
			end
		end
		return result;
	endfunction

	assign {free_any, free_idx}   = pick_lowest(~busy);
	assign {issue_any, issue_idx} = pick_lowest(busy & addr_ready & ~requested);
	assign {wb_any, wb_pick}      = pick_lowest(busy & data_valid);

	assign dispatch_ready = free_any;

	assign mem.req_valid = issue_any;
	assign mem.req_addr  = addr[issue_idx];
	assign mem.req_index = issue_idx;

	// A stalled writeback keeps its slot even if a lower one completes
	assign wb_sel      = wb_hold ? wb_hold_idx : wb_pick;
	assign wb_valid    = wb_any;
	assign wb_rob_idx  = rob_idx[wb_sel];
	assign wb_dest_tag = dest_tag[wb_sel];
	assign wb_data     = data[wb_sel];

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			wb_hold <= 1'b0;
		end else begin
			wb_hold <= wb_valid && !wb_ready;
		end
	end

	always_ff @(posedge clock) begin
		wb_hold_idx <= wb_sel;
	end

	for (genvar i = 0; i < lq_depth; i++) begin : g_entry
		assign alloc[i] = dispatch_valid && free_any && !flush &&
			(free_idx == lq_idx_w'(i));
		assign issue_grant[i]   = mem.req_valid && mem.req_ready &&
			(issue_idx == lq_idx_w'(i));
		assign resp_hit[i]      = mem.resp_valid && (mem.resp_index == lq_idx_w'(i));
		assign release_grant[i] = wb_valid && wb_ready && (wb_sel == lq_idx_w'(i));

		load_entry u_entry (
			.clock         (clock),
			.reset         (reset),
			.flush         (flush),
			.alloc         (alloc[i]),
			.alloc_req     (dispatch_req),
			.cdb_valid     (cdb_valid),
			.cdb_tag       (cdb_tag),
			.cdb_data      (cdb_data),
			.issue_grant   (issue_grant[i]),
			.resp_valid    (resp_hit[i]),
			.resp_data     (mem.resp_data),
			.release_grant (release_grant[i]),
			.busy          (busy[i]),
			.addr_ready    (addr_ready[i]),
			.addr          (addr[i]),
			.requested     (requested[i]),
			.data_valid    (data_valid[i]),
			.rob_idx       (rob_idx[i]),
			.dest_tag      (dest_tag[i]),
			.data          (data[i])
		);
	end

	// Writeback fields hold until the register file takes them
	a_wb_stable: assert property (
		@(posedge clock) disable iff (reset)
		wb_valid && !wb_ready && !flush |=>
			wb_valid && $stable(wb_rob_idx) && $stable(wb_dest_tag) && $stable(wb_data)
	);

endmodule

`default_nettype wire

//--- rtl/load_entry.sv
`timescale 1ns/1ps
`default_nettype none

module load_entry import lsu_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  logic             flush,

	// Allocation from dispatch
	input  logic             alloc,
	input  load_req_t        alloc_req,

	// Common data bus
	input  logic             cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  logic [xlen-1:0]  cdb_data,

	// Memory issue and response
	input  logic             issue_grant,
	input  logic             resp_valid,
	input  logic [xlen-1:0]  resp_data,

	// Writeback accepted for this slot
	input  logic             release_grant,

	output logic             busy,
	output logic             addr_ready,
	output logic [xlen-1:0]  addr,
	output logic             requested,
	output logic             data_valid,
	output logic [rob_w-1:0] rob_idx,
	output logic [tag_w-1:0] dest_tag,
	output logic [xlen-1:0]  data
);

	logic [xlen-1:0] base_q;    // Base value, or producer tag while waiting
	logic [xlen-1:0] imm_q;
	logic            cdb_hit;
	logic            cdb_bypass;

	// Waiting entry sees its producer on the CDB
	assign cdb_hit = busy && !addr_ready && cdb_valid &&
		(base_q[tag_w-1:0] == cdb_tag);

	// Producer broadcasts in the same cycle the load is dispatched
	assign cdb_bypass = cdb_valid && !alloc_req.base_ready &&
		(alloc_req.base[tag_w-1:0] == cdb_tag);

	assign addr = base_q + imm_q;    // Only meaningful once addr_ready

	// Progress flags
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			busy       <= 1'b0;
			addr_ready <= 1'b0;
			requested  <= 1'b0;
			data_valid <= 1'b0;
		end else if (alloc) begin
			busy       <= 1'b1;
			addr_ready <= alloc_req.base_ready || cdb_bypass;
			requested  <= 1'b0;
			data_valid <= 1'b0;
		end else if (release_grant) begin
			busy       <= 1'b0;
			addr_ready <= 1'b0;
			requested  <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			if (cdb_hit) begin
				addr_ready <= 1'b1;
			end
			if (issue_grant) begin
				requested <= 1'b1;
			end
			if (resp_valid && busy) begin
				data_valid <= 1'b1;
			end
		end
	end

	// Load payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			base_q   <= cdb_bypass ? cdb_data : alloc_req.base;
			imm_q    <= alloc_req.imm;
			rob_idx  <= alloc_req.rob_idx;
			dest_tag <= alloc_req.dest_tag;
		end else if (cdb_hit) begin
			base_q <= cdb_data;    // Tag replaced by the produced value
		end
		if (resp_valid) begin
			data <= resp_data;
		end
	end

	// The queue only allocates slots it sees as free
	a_alloc_free: assert property (
		@(posedge clock) disable iff (reset)
		alloc |-> !busy
	);

	// The memory port answers only a slot that has issued
	a_resp_requested: assert property (
		@(posedge clock) disable iff (reset)
		resp_valid |-> busy && requested
	);

endmodule

`default_nettype wire

//--- rtl/load_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface load_req_if import lsu_pkg::*; ();

	// Request side, queue to memory port
	logic                req_valid;
	logic                req_ready;
	logic [xlen-1:0]     req_addr;
	logic [lq_idx_w-1:0] req_index;    // Entry that owns the request

	// Response side, single cycle pulse with no back-pressure
	logic                resp_valid;
	logic [lq_idx_w-1:0] resp_index;
	logic [xlen-1:0]     resp_data;

	modport queue (
		output req_valid, req_addr, req_index,
		input  req_ready, resp_valid, resp_index, resp_data
	);

	modport port (
		input  req_valid, req_addr, req_index,
		output req_ready, resp_valid, resp_index, resp_data
	);

endinterface

`default_nettype wire

//--- rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// Data path and address width
	localparam int xlen = 32;

	// Load queue sizing
	localparam int lq_depth = 4;
	localparam int lq_idx_w = 2;    // Must cover lq_depth entries

	// Rename and reorder tags
	localparam int tag_w = 6;    // Physical register tag
	localparam int rob_w = 5;    // ROB index

	// One load as it leaves dispatch.
	// With base_ready low the low tag_w bits of base hold the producer tag
	typedef struct packed {
		logic [rob_w-1:0] rob_idx;
		logic [tag_w-1:0] dest_tag;
		logic             base_ready;
		logic [xlen-1:0]  base;
		logic [xlen-1:0]  imm;
	} load_req_t;

endpackage

`default_nettype wire
